// ==== addrgen.f ====
hw/addrgen_cfg_pkg.sv
hw/addrgen_beat_pkg.sv
hw/addrgen_ctrl_fsm.sv
hw/addrgen_cfg_regs.sv
hw/addrgen_loop_counters.sv
hw/addrgen_addr_strobe.sv
hw/addrgen_top.sv
testbench/addrgen_assert.sv
testbench/addrgen_tb.sv

// ==== Makefile ====
# Verilator flow for the streaming address generator
# make          build and run the testbench, exit status is the verdict
# make lint     lint the testbench and the RTL top level
# make clean    remove the build directory

VERILATOR  ?= verilator
TOP        ?= addrgen_tb
RTL_TOP    ?= addrgen_top
FILELIST   ?= addrgen.f
OBJ_DIR    ?= obj_dir
TIMESCALE  ?= 1ns/10ps
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
RTL_SRCS   ?= hw/addrgen_cfg_pkg.sv hw/addrgen_beat_pkg.sv hw/addrgen_ctrl_fsm.sv \
              hw/addrgen_cfg_regs.sv hw/addrgen_loop_counters.sv \
              hw/addrgen_addr_strobe.sv hw/addrgen_top.sv
TB_SRCS    ?= testbench/addrgen_assert.sv testbench/addrgen_tb.sv

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(RTL_SRCS) $(TB_SRCS)
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --timescale $(TIMESCALE) --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --timescale $(TIMESCALE) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/addrgen_patterns.txt ====
// job: base trans_size line_stride feat_stride line_length feat_length feat_roll loop_outer
// beat: addr strobe word_update line_update feat_update, first word is the job count
8
00001000 0004 0000 0000 0004 0001 0000 0 // aligned single loop
00001000 f 1 0 0
00001004 f 1 0 0
00001008 f 1 0 0
0000100c f 1 1 1
00002000 0008 0040 0100 0002 0003 0000 1 // positive line stride, feature step
00002000 f 1 0 0
00002004 f 1 1 0
00002040 f 1 0 0
00002044 f 1 1 0
00002080 f 1 0 0
00002084 f 1 1 1
00002100 f 1 0 0
00002104 f 1 1 0
00003000 0004 ffe0 0000 0002 0002 0000 0 // negative line stride
00003000 f 1 0 0
00003004 f 1 1 0
00002fe0 f 1 0 0
00002fe4 f 1 1 1
00004000 0008 0010 0080 0001 0002 0003 1 // outer mode, roll 3
00004000 f 1 1 0
00004010 f 1 1 1
00004000 f 1 1 0
00004010 f 1 1 1
00004000 f 1 1 0
00004010 f 1 1 1
00004080 f 1 1 0
00004090 f 1 1 1
00005000 0005 0010 0080 0001 0001 0003 0 // inner mode, roll 3
00005000 f 1 1 1
00005080 f 1 1 1
00005100 f 1 1 1
00005000 f 1 1 1
00005080 f 1 1 1
00006001 0006 0020 0000 0002 0002 0000 0 // misaligned base, extra word
00006000 e 1 0 0
00006004 f 1 0 0
00006008 1 1 1 0
00006020 e 1 0 0
00006024 f 1 0 0
00006028 1 1 1 1
00007000 0000 0000 0000 0001 0001 0000 0 // empty job
00008000 0002 0000 0000 0002 0001 0000 1 // short job after the empty one
00008000 f 1 0 0
00008004 f 1 1 1

// ==== testbench/addrgen_tb.sv ====
// testbench for the streaming address generator
// jobs and expected beats come from the patterns file, each job runs through
// the four-phase req/ack handshake with random enable_i stalls
// run from the project root so the patterns path resolves

`timescale 1ns/10ps
`default_nettype none

module addrgen_tb;
  import addrgen_cfg_pkg::*;
  import addrgen_beat_pkg::*;

  localparam int unsigned SEED      = 32'h41aa_fd89;
  localparam int          JOB_COLS  = 8; // words in a job line
  localparam int          BEAT_COLS = 5; // words in a beat line

  logic    clk_i, rst_ni, req_i, enable_i, loop_outer_i;
  addr_t   base_addr_i;
  trans_t  trans_size_i;
  stride_t line_stride_i, feat_stride_i;
  len_t    line_length_i, feat_length_i, feat_roll_i;
  logic    ack_o, gen_valid_o, busy_o;
  logic    word_update_o, line_update_o, feat_update_o;
  addr_t   gen_addr_o;
  strb_t   gen_strb_o;

  logic [31:0] pat_mem [512]; // flat list of hex words from the file
  int          pat_idx;       // next word to consume
  int          cycle_cnt;
  int          cycle_limit;

  addrgen_top uut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .ack_o         (ack_o),
    .enable_i      (enable_i),
    .base_addr_i   (base_addr_i),
    .trans_size_i  (trans_size_i),
    .line_stride_i (line_stride_i),
    .feat_stride_i (feat_stride_i),
    .line_length_i (line_length_i),
    .feat_length_i (feat_length_i),
    .feat_roll_i   (feat_roll_i),
    .loop_outer_i  (loop_outer_i),
    .gen_valid_o   (gen_valid_o),
    .gen_addr_o    (gen_addr_o),
    .gen_strb_o    (gen_strb_o),
    .word_update_o (word_update_o),
    .line_update_o (line_update_o),
    .feat_update_o (feat_update_o),
    .busy_o        (busy_o)
  );

  always #2 clk_i = ~clk_i; // 4 ns period

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (act !== exp) stop_run($sformatf("** Error %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_strb(input string name, input strb_t exp, input strb_t act);
    if (act !== exp) stop_run($sformatf("** Error %s expected %b actual %b", name, exp, act));
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) stop_run($sformatf("** Error %s expected %b actual %b", name, exp, act));
  endtask

  function automatic logic [31:0] pat_word(input int idx);
    return pat_mem[idx[8:0]];
  endfunction

  function automatic logic [31:0] pop_word();
    logic [31:0] w;
    w = pat_word(pat_idx);
    pat_idx = pat_idx + 1;
    return w;
  endfunction

  function automatic logic pick_enable();
    return ($urandom % 4) != 0; // stall roughly one cycle in four
  endfunction

  // watchdog limit is sized from the patterns before reset ends
  always @(posedge clk_i) begin
    if (rst_ni) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt > cycle_limit)
        stop_run($sformatf("timeout, jobs not finished after %0d cycles", cycle_cnt));
    end
  end

  task automatic run_job(input int job);
    int    beats;
    int    seen;
    int    hold;
    int    cyc;
    bit    done;
    string tag;
    @(negedge clk_i);
    if (ack_o || busy_o) stop_run($sformatf("job %0d: DUT not idle at job start", job));
    base_addr_i   = pop_word();
    trans_size_i  = trans_t'(pop_word());
    line_stride_i = stride_t'(pop_word());
    feat_stride_i = stride_t'(pop_word());
    line_length_i = len_t'(pop_word());
    feat_length_i = len_t'(pop_word());
    feat_roll_i   = len_t'(pop_word());
    loop_outer_i  = (pop_word() != 0);
    beats = int'(trans_size_i);
    seen  = 0;
    cyc   = 0;
    done  = 1'b0;
    req_i = 1'b1; // config held stable from here
    enable_i = pick_enable();
    while (!done) begin
      @(posedge clk_i);
      // busy from the cycle after the request until the last beat
      check_flag($sformatf("job %0d cycle %0d busy", job, cyc),
                 (cyc > 0) && (seen < beats), busy_o);
      if (gen_valid_o) begin
        if (seen >= beats) stop_run($sformatf("job %0d: more beats than trans_size", job));
        tag = $sformatf("job %0d beat %0d", job, seen);
        check_addr({tag, " addr"}, pop_word(), gen_addr_o);
        check_strb({tag, " strb"}, strb_t'(pop_word()), gen_strb_o);
        check_flag({tag, " word_update"}, pop_word() != 0, word_update_o);
        check_flag({tag, " line_update"}, pop_word() != 0, line_update_o);
        check_flag({tag, " feat_update"}, pop_word() != 0, feat_update_o);
        seen = seen + 1;
      end else if (word_update_o || line_update_o || feat_update_o) begin
        stop_run($sformatf("job %0d: update flag high without a beat", job));
      end
      if (ack_o) begin
        if (seen != beats)
          stop_run($sformatf("job %0d: ack_o after %0d of %0d beats", job, seen, beats));
        done = 1'b1;
      end
      cyc = cyc + 1;
      @(negedge clk_i);
      enable_i = done ? 1'b0 : pick_enable();
    end
    req_i = 1'b0; // release phase
    hold  = 0;
    while (ack_o) begin
      @(posedge clk_i);
      hold = hold + 1;
      if (ack_o && hold >= 2) stop_run($sformatf("job %0d: ack_o stuck after req_i fell", job));
    end
    if (busy_o) stop_run($sformatf("job %0d: busy_o high after the handshake", job));
  endtask

  initial begin
    int num_jobs;
    int total_beats;
    int scan;
    void'($urandom(SEED)); // single seed for the run
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    req_i         = 1'b0;
    enable_i      = 1'b0;
    base_addr_i   = '0;
    trans_size_i  = '0;
    line_stride_i = '0;
    feat_stride_i = '0;
    line_length_i = '0;
    feat_length_i = '0;
    feat_roll_i   = '0;
    loop_outer_i  = 1'b0;
    cycle_cnt     = 0;
    cycle_limit   = 0;
    pat_idx       = 1; // word 0 is the job count
    $readmemh("testbench/addrgen_patterns.txt", pat_mem);
    num_jobs = pat_word(0);
    if (num_jobs <= 0) stop_run("pattern file missing or holds no jobs");
    total_beats = 0;
    scan = 1;
    for (int j = 0; j < num_jobs; j++) begin // walk job lines for the beat counts
      total_beats = total_beats + pat_word(scan + 1);
      scan = scan + JOB_COLS + BEAT_COLS * pat_word(scan + 1);
    end
    cycle_limit = 4 * total_beats + 20 * num_jobs;
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    if (ack_o || gen_valid_o || busy_o || word_update_o || line_update_o || feat_update_o)
      stop_run("outputs not low after reset");
    for (int j = 0; j < num_jobs; j++) run_job(j);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/addrgen_assert.sv ====
// concurrent checks on the handshake and beat outputs of the address generator
// bound into addrgen_top and sampled on the rising clock edge

`timescale 1ns/10ps
`default_nettype none

module addrgen_assert (
  input wire logic clk_i,
  input wire logic rst_ni,
  input wire logic req_i,
  input wire logic ack_i,
  input wire logic gen_valid_i
);

  // ack only comes up for a pending request
  ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(ack_i) |-> req_i)
    else $error("ack_o rose while req_i was low");

  // ack follows req down in the next cycle of the release
  ack_release: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(req_i) |=> !ack_i)
    else $error("ack_o did not fall after req_i fell");

  // no beats once the job is acknowledged
  no_beat_in_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(gen_valid_i && ack_i))
    else $error("gen_valid_o high while ack_o high");

endmodule

bind addrgen_top addrgen_assert u_assert (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .req_i       (req_i),
  .ack_i       (ack_o),
  .gen_valid_i (gen_valid_o)
);

`default_nettype wire

// ==== hw/addrgen_top.sv ====
// streaming address generator for an accelerator memory port
// a job is started with req_i and finished when ack_o rises (four-phase)
// enable_i stalls the walk, one beat per enabled cycle while running
// walks words, lines and features and emits aligned address and strobe

`timescale 1ns/10ps
`default_nettype none

module addrgen_top #(
  parameter int unsigned CNT_W   = 10, // loop counter width
  parameter int unsigned TRANS_W = 16  // beat counter width
) (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  input  wire logic                     req_i,
  output logic                          ack_o,
  input  wire logic                     enable_i,
  input  wire addrgen_cfg_pkg::addr_t   base_addr_i,
  input  wire addrgen_cfg_pkg::trans_t  trans_size_i,
  input  wire addrgen_cfg_pkg::stride_t line_stride_i,
  input  wire addrgen_cfg_pkg::stride_t feat_stride_i,
  input  wire addrgen_cfg_pkg::len_t    line_length_i,
  input  wire addrgen_cfg_pkg::len_t    feat_length_i,
  input  wire addrgen_cfg_pkg::len_t    feat_roll_i,
  input  wire logic                     loop_outer_i,
  output logic                          gen_valid_o,
  output addrgen_cfg_pkg::addr_t        gen_addr_o,
  output addrgen_beat_pkg::strb_t       gen_strb_o,
  output logic                          word_update_o,
  output logic                          line_update_o,
  output logic                          feat_update_o,
  output logic                          busy_o
);
  import addrgen_cfg_pkg::*;

  logic    capture, clear, step; // fsm strobes
  addr_t   base_addr;
  stride_t line_stride, feat_stride;
  len_t    words_m1, lines_m1, roll_m1; // captured loop limits
  logic    roll_zero, loop_outer, misaligned;
  addr_t   word_off, line_off, feat_off; // loop offsets in bytes
  logic    first_word, last_word;

  assign gen_valid_o = step; // beat issued in the same cycle

  addrgen_ctrl_fsm #(
    .TRANS_W (TRANS_W)
  ) u_ctrl_fsm (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .enable_i     (enable_i),
    .trans_size_i (trans_size_i),
    .capture_o    (capture),
    .clear_o      (clear),
    .step_o       (step),
    .busy_o       (busy_o),
    .ack_o        (ack_o)
  );

  addrgen_cfg_regs u_cfg_regs (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .capture_i     (capture),
    .base_addr_i   (base_addr_i),
    .line_stride_i (line_stride_i),
    .feat_stride_i (feat_stride_i),
    .line_length_i (line_length_i),
    .feat_length_i (feat_length_i),
    .feat_roll_i   (feat_roll_i),
    .loop_outer_i  (loop_outer_i),
    .base_addr_o   (base_addr),
    .line_stride_o (line_stride),
    .feat_stride_o (feat_stride),
    .words_m1_o    (words_m1),
    .lines_m1_o    (lines_m1),
    .roll_m1_o     (roll_m1),
    .roll_zero_o   (roll_zero),
    .loop_outer_o  (loop_outer),
    .misaligned_o  (misaligned)
  );

  addrgen_loop_counters #(
    .CNT_W (CNT_W)
  ) u_loop_counters (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .clear_i       (clear),
    .step_i        (step),
    .line_stride_i (line_stride),
    .feat_stride_i (feat_stride),
    .words_m1_i    (words_m1),
    .lines_m1_i    (lines_m1),
    .roll_m1_i     (roll_m1),
    .roll_zero_i   (roll_zero),
    .loop_outer_i  (loop_outer),
    .word_off_o    (word_off),
    .line_off_o    (line_off),
    .feat_off_o    (feat_off),
    .first_word_o  (first_word),
    .last_word_o   (last_word),
    .word_update_o (word_update_o),
    .line_update_o (line_update_o),
    .feat_update_o (feat_update_o)
  );

  addrgen_addr_strobe u_addr_strobe (
    .base_addr_i  (base_addr),
    .word_off_i   (word_off),
    .line_off_i   (line_off),
    .feat_off_i   (feat_off),
    .misaligned_i (misaligned),
    .first_word_i (first_word),
    .last_word_i  (last_word),
    .gen_addr_o   (gen_addr_o),
    .gen_strb_o   (gen_strb_o)
  );

endmodule

`default_nettype wire

// ==== hw/addrgen_addr_strobe.sv ====
// address and strobe generation of the address generator
// purely combinational, sums base and loop offsets
// emits the word-aligned address and the byte lanes of the current word

`timescale 1ns/10ps
`default_nettype none

module addrgen_addr_strobe (
  input  wire addrgen_cfg_pkg::addr_t base_addr_i,
  input  wire addrgen_cfg_pkg::addr_t word_off_i,
  input  wire addrgen_cfg_pkg::addr_t line_off_i,
  input  wire addrgen_cfg_pkg::addr_t feat_off_i,
  input  wire logic                   misaligned_i,
  input  wire logic                   first_word_i,
  input  wire logic                   last_word_i,
  output addrgen_cfg_pkg::addr_t      gen_addr_o,
  output addrgen_beat_pkg::strb_t     gen_strb_o
);
  import addrgen_beat_pkg::*;

  addr_u sum;     // byte address of the current beat
  addr_u aligned; // same word with the offset dropped

  assign sum.raw = base_addr_i + feat_off_i + line_off_i + word_off_i;

  assign aligned.word.index  = sum.word.index;
  assign aligned.word.offset = '0;
  assign gen_addr_o = aligned.raw;

  always_comb begin
    gen_strb_o = '1; // full word when aligned
    if (misaligned_i) begin
      if (first_word_i) gen_strb_o = gen_strb_o << sum.word.offset; // skip leading bytes
      if (last_word_i) gen_strb_o = ~(gen_strb_o << sum.word.offset); // tail bytes only
    end
  end

endmodule

`default_nettype wire

// ==== hw/addrgen_loop_counters.sv ====
// word, line and feature loop nest of the address generator
// one iteration per step, offsets accumulate in bytes
// feature roll behaves as an outer or inner loop per loop_outer_i
// also flags which loop levels were updated by the current step

`timescale 1ns/10ps
`default_nettype none

module addrgen_loop_counters #(
  parameter int unsigned CNT_W = 10 // loop counter width
) (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  input  wire logic                     clear_i,
  input  wire logic                     step_i,
  input  wire addrgen_cfg_pkg::stride_t line_stride_i,
  input  wire addrgen_cfg_pkg::stride_t feat_stride_i,
  input  wire addrgen_cfg_pkg::len_t    words_m1_i,
  input  wire addrgen_cfg_pkg::len_t    lines_m1_i,
  input  wire addrgen_cfg_pkg::len_t    roll_m1_i,
  input  wire logic                     roll_zero_i,
  input  wire logic                     loop_outer_i,
  output addrgen_cfg_pkg::addr_t        word_off_o,
  output addrgen_cfg_pkg::addr_t        line_off_o,
  output addrgen_cfg_pkg::addr_t        feat_off_o,
  output logic                          first_word_o,
  output logic                          last_word_o,
  output logic                          word_update_o,
  output logic                          line_update_o,
  output logic                          feat_update_o
);
  import addrgen_cfg_pkg::*;
  import addrgen_beat_pkg::*;

  logic [CNT_W-1:0] word_cnt_q, line_cnt_q, feat_cnt_q;
  addr_t            line_step, feat_step; // sign-extended strides
  logic             last_line, at_roll, below_roll;

  assign line_step = addr_t'(line_stride_i);
  assign feat_step = addr_t'(feat_stride_i);

  assign last_word_o = (len_t'(word_cnt_q) >= words_m1_i);
  assign last_line   = (len_t'(line_cnt_q) >= lines_m1_i);
  assign first_word_o = (word_cnt_q == '0);

  // zero roll count counts as both at and below the last roll
  assign at_roll    = (len_t'(feat_cnt_q) == roll_m1_i) || roll_zero_i;
  assign below_roll = (len_t'(feat_cnt_q) < roll_m1_i) || roll_zero_i;

  assign word_update_o = step_i;
  assign line_update_o = step_i && last_word_o;
  assign feat_update_o = step_i && last_word_o && last_line;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      word_cnt_q <= '0;
      line_cnt_q <= '0;
      feat_cnt_q <= '0;
      word_off_o <= '0;
      line_off_o <= '0;
      feat_off_o <= '0;
    end else if (clear_i) begin // fresh job starts from zero offsets
      word_cnt_q <= '0;
      line_cnt_q <= '0;
      feat_cnt_q <= '0;
      word_off_o <= '0;
      line_off_o <= '0;
      feat_off_o <= '0;
    end else if (step_i) begin
      if (!last_word_o) begin
        word_cnt_q <= word_cnt_q + CNT_W'(1);
        word_off_o <= word_off_o + addr_t'(STEP_BYTES);
      end else if (!last_line) begin // next line
        word_cnt_q <= '0;
        word_off_o <= '0;
        line_cnt_q <= line_cnt_q + CNT_W'(1);
        line_off_o <= line_off_o + line_step;
      end else begin // end of feature, apply roll rule
        word_cnt_q <= '0;
        word_off_o <= '0;
        line_cnt_q <= '0;
        line_off_o <= '0;
        if (loop_outer_i) begin
          if (at_roll) begin
            feat_cnt_q <= '0;
            feat_off_o <= feat_off_o + feat_step;
          end else begin
            feat_cnt_q <= feat_cnt_q + CNT_W'(1); // replay same feature
          end
        end else if (below_roll) begin
          feat_cnt_q <= feat_cnt_q + CNT_W'(1);
          feat_off_o <= feat_off_o + feat_step;
        end else begin // inner roll done, back to first feature
          feat_cnt_q <= '0;
          feat_off_o <= '0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/addrgen_cfg_regs.sv ====
// job configuration registers of the address generator
// sampled on capture, stable for the whole job
// also precomputes the loop limits and the misalignment flag

`timescale 1ns/10ps
`default_nettype none

module addrgen_cfg_regs (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  input  wire logic                     capture_i,
  input  wire addrgen_cfg_pkg::addr_t   base_addr_i,
  input  wire addrgen_cfg_pkg::stride_t line_stride_i,
  input  wire addrgen_cfg_pkg::stride_t feat_stride_i,
  input  wire addrgen_cfg_pkg::len_t    line_length_i,
  input  wire addrgen_cfg_pkg::len_t    feat_length_i,
  input  wire addrgen_cfg_pkg::len_t    feat_roll_i,
  input  wire logic                     loop_outer_i,
  output addrgen_cfg_pkg::addr_t        base_addr_o,
  output addrgen_cfg_pkg::stride_t      line_stride_o,
  output addrgen_cfg_pkg::stride_t      feat_stride_o,
  output addrgen_cfg_pkg::len_t         words_m1_o, // last word index in a line
  output addrgen_cfg_pkg::len_t         lines_m1_o, // last line index in a feature
  output addrgen_cfg_pkg::len_t         roll_m1_o,  // last roll index
  output logic                          roll_zero_o,
  output logic                          loop_outer_o,
  output logic                          misaligned_o
);
  import addrgen_cfg_pkg::*;

  logic misaligned_d;
  len_t words_m1_d;

  // any unaligned term shifts every line by a partial word
  assign misaligned_d = (base_addr_i[1:0] != 2'b00) || (line_stride_i[1:0] != 2'b00) ||
                        (feat_stride_i[1:0] != 2'b00);
  assign words_m1_d = misaligned_d ? line_length_i : line_length_i - len_t'(1); // extra word

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      words_m1_o   <= '0;
      lines_m1_o   <= '0;
      roll_m1_o    <= '0;
      roll_zero_o  <= 1'b0;
      loop_outer_o <= 1'b0;
      misaligned_o <= 1'b0;
    end else if (capture_i) begin
      words_m1_o   <= words_m1_d;
      lines_m1_o   <= feat_length_i - len_t'(1);
      roll_m1_o    <= feat_roll_i - len_t'(1);
      roll_zero_o  <= (feat_roll_i == '0);
      loop_outer_o <= loop_outer_i;
      misaligned_o <= misaligned_d;
    end
  end

  // address and strides only matter while running
  always_ff @(posedge clk_i) begin
    if (capture_i) begin
      base_addr_o   <= base_addr_i;
      line_stride_o <= line_stride_i;
      feat_stride_o <= feat_stride_i;
    end
  end

endmodule

`default_nettype wire

// ==== hw/addrgen_ctrl_fsm.sv ====
// job control of the address generator
// four-phase req/ack handshake around a run of trans_size beats
// issues capture and clear at job start, counts beats while running

`timescale 1ns/10ps
`default_nettype none

module addrgen_ctrl_fsm #(
  parameter int unsigned TRANS_W = 16 // beat counter width
) (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  input  wire logic                    req_i,
  input  wire logic                    enable_i,
  input  wire addrgen_cfg_pkg::trans_t trans_size_i, // stable while req_i high
  output logic                         capture_o,
  output logic                         clear_o,
  output logic                         step_o,
  output logic                         busy_o,
  output logic                         ack_o
);

  localparam logic [1:0] IDLE = 2'd0;
  localparam logic [1:0] RUN  = 2'd1;
  localparam logic [1:0] DONE = 2'd2;

  logic [1:0]         state_q, state_d;
  logic [TRANS_W-1:0] trans_cnt_q; // beats issued so far
  logic               beat_last;   // current step issues the final beat
  logic               size_zero;

  assign size_zero = (trans_size_i == '0);
  assign beat_last = ((trans_cnt_q + TRANS_W'(1)) == TRANS_W'(trans_size_i));

  assign step_o = (state_q == RUN) && enable_i;
  assign busy_o = (state_q == RUN);
  assign ack_o  = (state_q == DONE); // held until req_i drops

  always_comb begin
    state_d   = state_q;
    capture_o = 1'b0;
    clear_o   = 1'b0;
    case (state_q)
      IDLE: begin
        if (req_i) begin
          capture_o = 1'b1; // config sampled in this cycle
          clear_o   = 1'b1;
          state_d   = size_zero ? DONE : RUN; // empty job acks at once
        end
      end
      RUN: begin
        if (step_o && beat_last) state_d = DONE;
      end
      DONE: begin
        if (!req_i) state_d = IDLE; // ack drops one cycle after req
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      trans_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (clear_o) trans_cnt_q <= '0;
      else if (step_o) trans_cnt_q <= trans_cnt_q + TRANS_W'(1);
    end
  end

endmodule

`default_nettype wire

// ==== hw/addrgen_beat_pkg.sv ====
// definitions of the beats emitted on the memory port
// one beat is a word-aligned address plus a byte strobe
// the address union splits a byte address into word index and byte offset

`default_nettype none

package addrgen_beat_pkg;

  localparam int unsigned STEP_BYTES = 4; // bytes per memory word
  localparam int unsigned OFFSET_W   = 2; // log2 of STEP_BYTES

  // one enable bit per byte lane
  typedef logic [STEP_BYTES-1:0] strb_t;

  // same 32 bits seen as a byte address or as word index and offset
  typedef union packed {
    addrgen_cfg_pkg::addr_t raw;
    struct packed {
      logic [31-OFFSET_W:0] index; // word number
      logic [OFFSET_W-1:0]  offset; // byte within the word
    } word;
  } addr_u;

endpackage

`default_nettype wire

// ==== hw/addrgen_cfg_pkg.sv ====
// job configuration types of the streaming address generator
// shared by the top level, the configuration registers and the loop counters
// lengths and roll counts are unsigned, strides are signed byte distances

`default_nettype none

package addrgen_cfg_pkg;

  // byte address in the accelerator memory space
  typedef logic [31:0] addr_t;

  // distance between lines or features in bytes, may be negative
  typedef logic signed [15:0] stride_t;

  // loop length in words or lines, also used for the feature roll count
  typedef logic [15:0] len_t;

  // number of beats in one job
  typedef logic [15:0] trans_t;

endpackage

`default_nettype wire
